//--- bank_arbiter.sv
//////////////////////////////
// Arbiter of one VRF bank, grant in the same cycle.
// Read A and the ALU always mask read B and the load unit.
// Each pair takes turns after every grant it receives.
//////////////////////////////

module bank_arbiter #(
  parameter int unsigned BANK = 0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  vrf_port_if.arbiter       rd_a,
  vrf_port_if.arbiter       rd_b,
  vrf_port_if.arbiter       alu,
  vrf_port_if.arbiter       ldu,
  output logic              vrf_req_o,
  output vrf_pkg::row_t     vrf_row_o,
  output logic              vrf_wen_o,
  output vrf_pkg::elen_t    vrf_wdata_o,
  output vrf_pkg::strb_t    vrf_be_o,
  output vrf_pkg::master_e  vrf_src_o
);

  logic a_hit, b_hit, alu_hit, ldu_hit;
  logic hp_any, lp_any;
  logic hp_alu_first_q, lp_ldu_first_q;
  logic gnt_a, gnt_b, gnt_alu, gnt_ldu;

  // Requests that target this bank
  assign a_hit   = rd_a.req && (rd_a.addr.rb.bank == vrf_pkg::bank_t'(BANK));
  assign b_hit   = rd_b.req && (rd_b.addr.rb.bank == vrf_pkg::bank_t'(BANK));
  assign alu_hit = alu.req && (alu.addr.rb.bank == vrf_pkg::bank_t'(BANK));
  assign ldu_hit = ldu.req && (ldu.addr.rb.bank == vrf_pkg::bank_t'(BANK));

  assign hp_any = a_hit || alu_hit;
  assign lp_any = b_hit || ldu_hit;

  ////////////////////////////////
  // Grants
  ////////////////////////////////

  assign gnt_alu = alu_hit && (!a_hit || hp_alu_first_q);
  assign gnt_a   = a_hit && !gnt_alu;
  // Low group only when the high group is silent here
  assign gnt_ldu = !hp_any && ldu_hit && (!b_hit || lp_ldu_first_q);
  assign gnt_b   = !hp_any && b_hit && !gnt_ldu;

  assign rd_a.bank_gnt[BANK] = gnt_a;
  assign rd_b.bank_gnt[BANK] = gnt_b;
  assign alu.bank_gnt[BANK]  = gnt_alu;
  assign ldu.bank_gnt[BANK]  = gnt_ldu;

  // The bank always accepts
  assign vrf_req_o = hp_any || lp_any;

  assign vrf_src_o = gnt_alu ? vrf_pkg::ALU :
                     gnt_b   ? vrf_pkg::READ_B :
                     gnt_ldu ? vrf_pkg::LDU : vrf_pkg::READ_A;

  ////////////////////////////////
  // Payload of the winner
  ////////////////////////////////

  always_comb begin
    unique case (vrf_src_o)
      vrf_pkg::READ_B: begin
        vrf_row_o   = rd_b.addr.rb.row;
        vrf_wen_o   = rd_b.wen;
        vrf_wdata_o = rd_b.wdata;
        vrf_be_o    = rd_b.be;
      end
      vrf_pkg::ALU: begin
        vrf_row_o   = alu.addr.rb.row;
        vrf_wen_o   = alu.wen;
        vrf_wdata_o = alu.wdata;
        vrf_be_o    = alu.be;
      end
      vrf_pkg::LDU: begin
        vrf_row_o   = ldu.addr.rb.row;
        vrf_wen_o   = ldu.wen;
        vrf_wdata_o = ldu.wdata;
        vrf_be_o    = ldu.be;
      end
      default: begin
        vrf_row_o   = rd_a.addr.rb.row;
        vrf_wen_o   = rd_a.wen;
        vrf_wdata_o = rd_a.wdata;
        vrf_be_o    = rd_a.be;
      end
    endcase
  end

  // Round-robin turn of each group moves on a grant in that group
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hp_alu_first_q <= 1'b0;
      lp_ldu_first_q <= 1'b0;
    end else begin
      if (gnt_a || gnt_alu) begin
        hp_alu_first_q <= gnt_a;
      end
      if (gnt_b || gnt_ldu) begin
        lp_ldu_first_q <= gnt_b;
      end
    end
  end

endmodule

//--- load_stage.sv
//////////////////////////////
// One-entry stream register for load results.
// A stored beat writes the VRF from the next cycle on and
// a new beat is taken in the cycle the entry drains.
//////////////////////////////

module load_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ldu_req_i,
  input  vrf_pkg::word_addr_u ldu_addr_i,
  input  vrf_pkg::elen_t      ldu_wdata_i,
  input  vrf_pkg::strb_t      ldu_be_i,
  output logic                ldu_gnt_o,
  vrf_port_if.master          port
);

  logic                full_q;
  logic                drain;
  vrf_pkg::word_addr_u addr_q;
  vrf_pkg::elen_t      wdata_q;
  vrf_pkg::strb_t      be_q;

  assign drain     = full_q && port.gnt;
  assign ldu_gnt_o = ldu_req_i && (!full_q || drain);

  // Stored beat as a write request
  assign port.req   = full_q;
  assign port.addr  = addr_q;
  assign port.wen   = 1'b1;
  assign port.wdata = wdata_q;
  assign port.be    = be_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else begin
      full_q <= ldu_gnt_o || (full_q && !drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_gnt_o) begin
      addr_q  <= ldu_addr_i;
      wdata_q <= ldu_wdata_i;
      be_q    <= ldu_be_i;
    end
  end

endmodule

//--- operand_requester.f
+incdir+.
vrf_pkg.sv
opreq_pkg.sv
vrf_port_if.sv
read_requester.sv
load_stage.sv
bank_arbiter.sv
operand_requester.sv
operand_requester_props.sv
tb_operand_requester.sv

//--- operand_requester.sv
//////////////////////////////
// Operand request and bank arbitration core of one lane.
// Every asserted vrf_req_o is a completed access. ALU results
// are not buffered and must hold until alu_gnt_o.
//////////////////////////////

`include "opreq_macros.svh"

module operand_requester (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Read commands and operand queues, index 0 is A
  input  logic                     [1:0]                   cmd_valid_i,
  input  vrf_pkg::word_addr_u      [1:0]                   cmd_addr_i,
  input  opreq_pkg::vl_t           [1:0]                   cmd_vl_i,
  input  opreq_pkg::eew_e          [1:0]                   cmd_eew_i,
  output logic                     [1:0]                   cmd_ready_o,
  input  logic                     [1:0]                   queue_ready_i,
  output logic                     [1:0]                   issued_o,
  // ALU writer
  input  logic                                             alu_req_i,
  input  vrf_pkg::word_addr_u                              alu_addr_i,
  input  vrf_pkg::elen_t                                   alu_wdata_i,
  input  vrf_pkg::strb_t                                   alu_be_i,
  output logic                                             alu_gnt_o,
  // Load writer
  input  logic                                             ldu_req_i,
  input  vrf_pkg::word_addr_u                              ldu_addr_i,
  input  vrf_pkg::elen_t                                   ldu_wdata_i,
  input  vrf_pkg::strb_t                                   ldu_be_i,
  output logic                                             ldu_gnt_o,
  // VRF banks
  output logic                     [`OPREQ_NR_BANKS-1:0]   vrf_req_o,
  output vrf_pkg::row_t            [`OPREQ_NR_BANKS-1:0]   vrf_row_o,
  output logic                     [`OPREQ_NR_BANKS-1:0]   vrf_wen_o,
  output vrf_pkg::elen_t           [`OPREQ_NR_BANKS-1:0]   vrf_wdata_o,
  output vrf_pkg::strb_t           [`OPREQ_NR_BANKS-1:0]   vrf_be_o,
  output vrf_pkg::master_e         [`OPREQ_NR_BANKS-1:0]   vrf_src_o
);

  opreq_pkg::read_cmd_t [1:0] cmd;

  vrf_port_if rd_a_if ();
  vrf_port_if rd_b_if ();
  vrf_port_if alu_if ();
  vrf_port_if ldu_if ();

  // A master is granted when any bank grants it
  assign rd_a_if.gnt = |rd_a_if.bank_gnt;
  assign rd_b_if.gnt = |rd_b_if.bank_gnt;
  assign alu_if.gnt  = |alu_if.bank_gnt;
  assign ldu_if.gnt  = |ldu_if.bank_gnt;

  ////////////////////////////////
  // Read requesters
  ////////////////////////////////

  for (genvar q = 0; q < 2; q++) begin : gen_cmd
    assign cmd[q] = '{addr: cmd_addr_i[q], vl: cmd_vl_i[q], eew: cmd_eew_i[q]};
  end

  read_requester u_read_a (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i[0]),
    .cmd_i         (cmd[0]),
    .cmd_ready_o   (cmd_ready_o[0]),
    .queue_ready_i (queue_ready_i[0]),
    .issued_o      (issued_o[0]),
    .port          (rd_a_if)
  );

  read_requester u_read_b (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i[1]),
    .cmd_i         (cmd[1]),
    .cmd_ready_o   (cmd_ready_o[1]),
    .queue_ready_i (queue_ready_i[1]),
    .issued_o      (issued_o[1]),
    .port          (rd_b_if)
  );

  ////////////////////////////////
  // Writers
  ////////////////////////////////

  assign alu_if.req   = alu_req_i;
  assign alu_if.addr  = alu_addr_i;
  assign alu_if.wen   = 1'b1;
  assign alu_if.wdata = alu_wdata_i;
  assign alu_if.be    = alu_be_i;
  assign alu_gnt_o    = alu_if.gnt;

  load_stage u_load_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ldu_req_i   (ldu_req_i),
    .ldu_addr_i  (ldu_addr_i),
    .ldu_wdata_i (ldu_wdata_i),
    .ldu_be_i    (ldu_be_i),
    .ldu_gnt_o   (ldu_gnt_o),
    .port        (ldu_if)
  );

  // One arbiter per bank
  for (genvar b = 0; b < `OPREQ_NR_BANKS; b++) begin : gen_bank
    bank_arbiter #(
      .BANK (b)
    ) u_bank_arbiter (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .rd_a        (rd_a_if),
      .rd_b        (rd_b_if),
      .alu         (alu_if),
      .ldu         (ldu_if),
      .vrf_req_o   (vrf_req_o[b]),
      .vrf_row_o   (vrf_row_o[b]),
      .vrf_wen_o   (vrf_wen_o[b]),
      .vrf_wdata_o (vrf_wdata_o[b]),
      .vrf_be_o    (vrf_be_o[b]),
      .vrf_src_o   (vrf_src_o[b])
    );
  end

endmodule

//--- operand_requester_props.sv
//////////////////////////////
// Assertions bound into the operand requester top.
// fail_cnt counts every failed assertion for the testbench.
// Small reference models track read words and load beats.
//////////////////////////////

`include "opreq_macros.svh"

module operand_requester_props (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic                  [1:0]                   cmd_valid_i,
  input vrf_pkg::word_addr_u   [1:0]                   cmd_addr_i,
  input opreq_pkg::vl_t        [1:0]                   cmd_vl_i,
  input opreq_pkg::eew_e       [1:0]                   cmd_eew_i,
  input logic                  [1:0]                   cmd_ready_o,
  input logic                  [1:0]                   queue_ready_i,
  input logic                  [1:0]                   issued_o,
  input logic                                          alu_req_i,
  input vrf_pkg::word_addr_u                           alu_addr_i,
  input vrf_pkg::elen_t                                alu_wdata_i,
  input vrf_pkg::strb_t                                alu_be_i,
  input logic                                          alu_gnt_o,
  input logic                                          ldu_req_i,
  input vrf_pkg::word_addr_u                           ldu_addr_i,
  input vrf_pkg::elen_t                                ldu_wdata_i,
  input vrf_pkg::strb_t                                ldu_be_i,
  input logic                                          ldu_gnt_o,
  input logic                  [`OPREQ_NR_BANKS-1:0]   vrf_req_o,
  input vrf_pkg::row_t         [`OPREQ_NR_BANKS-1:0]   vrf_row_o,
  input logic                  [`OPREQ_NR_BANKS-1:0]   vrf_wen_o,
  input vrf_pkg::elen_t        [`OPREQ_NR_BANKS-1:0]   vrf_wdata_o,
  input vrf_pkg::strb_t        [`OPREQ_NR_BANKS-1:0]   vrf_be_o,
  input vrf_pkg::master_e      [`OPREQ_NR_BANKS-1:0]   vrf_src_o
);

  int unsigned fail_cnt = 0;

  logic                       started_q;
  logic [8:0]                 left_q [2];
  vrf_pkg::word_addr_u        rd_addr_q [2];
  int unsigned                alu_wait_q;
  int unsigned                a_wait_q;
  vrf_pkg::word_addr_u        ld_addr_q [4];
  vrf_pkg::elen_t             ld_data_q [4];
  vrf_pkg::strb_t             ld_be_q [4];
  logic [1:0]                 ld_wr_q;
  logic [1:0]                 ld_rd_q;
  logic [2:0]                 ld_cnt_q;
  logic [`OPREQ_NR_BANKS-1:0] ld_hit;
  logic                       ld_pop;
  vrf_pkg::bank_t             alu_bank;

  // Words needed to cover vl elements, rounded up
  function automatic logic [8:0] words_of(opreq_pkg::vl_t vl, opreq_pkg::eew_e eew);
    logic [8:0] epw;
    case (eew)
      opreq_pkg::EW8:  epw = 9'd8;
      opreq_pkg::EW16: epw = 9'd4;
      opreq_pkg::EW32: epw = 9'd2;
      default:         epw = 9'd1;
    endcase
    return ({1'b0, vl} + epw - 9'd1) / epw;
  endfunction

  assign ld_pop   = |ld_hit;
  assign alu_bank = alu_addr_i.rb.bank;

  ////////////////////////////////
  // Reference models
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q  <= 1'b0;
      left_q     <= '{default: '0};
      rd_addr_q  <= '{default: '0};
      alu_wait_q <= 0;
      a_wait_q   <= 0;
      ld_wr_q    <= '0;
      ld_rd_q    <= '0;
      ld_cnt_q   <= '0;
    end else begin
      started_q <= started_q || (|cmd_valid_i) || alu_req_i || ldu_req_i;
      for (int q = 0; q < 2; q++) begin
        if (issued_o[q]) begin
          left_q[q]        <= left_q[q] - 9'd1;
          rd_addr_q[q].idx <= rd_addr_q[q].idx + 1'b1;
        end
        if (cmd_valid_i[q] && cmd_ready_o[q]) begin
          left_q[q]    <= words_of(cmd_vl_i[q], cmd_eew_i[q]);
          rd_addr_q[q] <= cmd_addr_i[q];
        end
      end
      alu_wait_q <= (alu_req_i && !alu_gnt_o) ? alu_wait_q + 1 : 0;
      // Read A asks whenever words are left and its queue has room
      a_wait_q <= (left_q[0] != '0 && queue_ready_i[0] && !issued_o[0]) ? a_wait_q + 1 : 0;
      if (ldu_gnt_o) begin
        ld_wr_q <= ld_wr_q + 1'b1;
      end
      if (ld_pop) begin
        ld_rd_q <= ld_rd_q + 1'b1;
      end
      ld_cnt_q <= ld_cnt_q + 3'(ldu_gnt_o) - 3'(ld_pop);
    end
  end

  // Accepted load beats in order
  always_ff @(posedge clk_i) begin
    if (ldu_gnt_o) begin
      ld_addr_q[ld_wr_q] <= ldu_addr_i;
      ld_data_q[ld_wr_q] <= ldu_wdata_i;
      ld_be_q[ld_wr_q]   <= ldu_be_i;
    end
  end

  ////////////////////////////////
  // Properties
  ////////////////////////////////

  // Quiet outputs from reset until the first stimulus
  a_idle: assert property (@(posedge clk_i)
    !started_q && cmd_valid_i == '0 && !alu_req_i && !ldu_req_i |->
    cmd_ready_o == 2'b11 && vrf_req_o == '0 && issued_o == '0 && !alu_gnt_o &&
    !ldu_gnt_o)
    else begin
      fail_cnt++;
      $error("** Error idle cmd_ready_o=%h vrf_req_o=%h issued_o=%h alu_gnt_o=%h ldu_gnt_o=%h",
             $sampled(cmd_ready_o), $sampled(vrf_req_o), $sampled(issued_o),
             $sampled(alu_gnt_o), $sampled(ldu_gnt_o));
    end

  for (genvar q = 0; q < 2; q++) begin : gen_rd
    localparam vrf_pkg::master_e Src = (q == 0) ? vrf_pkg::READ_A : vrf_pkg::READ_B;

    vrf_pkg::bank_t bank;

    assign bank = rd_addr_q[q].rb.bank;

    // Ready again only once every word of the command is out
    a_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_ready_o[q] |-> left_q[q] == {8'd0, issued_o[q]})
      else begin
        fail_cnt++;
        $error("** Error queue %0d words left = %h, issued_o = %h",
               q, $sampled(left_q[q]), $sampled(issued_o[q]));
      end

    a_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
      issued_o[q] |-> left_q[q] != '0 && vrf_req_o[bank] && !vrf_wen_o[bank] &&
      vrf_src_o[bank] == Src && vrf_row_o[bank] == rd_addr_q[q].rb.row)
      else begin
        fail_cnt++;
        $error("** Error queue %0d bank %h vrf_row_o = %h, expected %h, vrf_src_o = %h",
               q, $sampled(bank), $sampled(vrf_row_o[bank]),
               $sampled(rd_addr_q[q].rb.row), $sampled(vrf_src_o[bank]));
      end
  end

  a_alu_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_gnt_o |-> vrf_req_o[alu_bank] && vrf_wen_o[alu_bank] &&
    vrf_src_o[alu_bank] == vrf_pkg::ALU && vrf_row_o[alu_bank] == alu_addr_i.rb.row &&
    vrf_wdata_o[alu_bank] == alu_wdata_i && vrf_be_o[alu_bank] == alu_be_i)
    else begin
      fail_cnt++;
      $error("** Error ALU bank %h vrf_wdata_o = %h, expected %h, vrf_row_o = %h, expected %h",
             $sampled(alu_bank), $sampled(vrf_wdata_o[alu_bank]), $sampled(alu_wdata_i),
             $sampled(vrf_row_o[alu_bank]), $sampled(alu_addr_i.rb.row));
    end

  // The high group masks the low group
  a_alu_prio: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_req_i |-> vrf_src_o[alu_bank] inside {vrf_pkg::READ_A, vrf_pkg::ALU})
    else begin
      fail_cnt++;
      $error("** Error bank %h vrf_src_o = %h under an ALU request",
             $sampled(alu_bank), $sampled(vrf_src_o[alu_bank]));
    end

  a_fair: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_wait_q <= 2 && a_wait_q <= 2)
    else begin
      fail_cnt++;
      $error("The ALU or read A waited more than 2 cycles for a grant");
    end

  for (genvar b = 0; b < `OPREQ_NR_BANKS; b++) begin : gen_ld
    assign ld_hit[b] = vrf_req_o[b] && (vrf_src_o[b] == vrf_pkg::LDU);

    a_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ld_hit[b] |-> ld_cnt_q != '0 && vrf_wen_o[b] &&
      ld_addr_q[ld_rd_q].rb.bank == vrf_pkg::bank_t'(b) &&
      ld_addr_q[ld_rd_q].rb.row == vrf_row_o[b] &&
      ld_data_q[ld_rd_q] == vrf_wdata_o[b] && ld_be_q[ld_rd_q] == vrf_be_o[b])
      else begin
        fail_cnt++;
        $error("** Error bank %0d LDU vrf_wdata_o = %h, expected %h, pending beats = %h",
               b, $sampled(vrf_wdata_o[b]), $sampled(ld_data_q[ld_rd_q]), $sampled(ld_cnt_q));
      end
  end

endmodule

//--- opreq_macros.svh
//////////////////////////////
// Geometry of the banked VRF and the read command widths.
// Consecutive word addresses alternate banks, so NR_BANKS must
// be a power of two.
//////////////////////////////

`ifndef OPREQ_MACROS_SVH
`define OPREQ_MACROS_SVH

// Number of VRF banks
`define OPREQ_NR_BANKS 2

// Rows in each bank
`define OPREQ_NR_ROWS 16

// Data word width in bits
`define OPREQ_ELEN 64

// Byte enables per word
`define OPREQ_STRB_W (`OPREQ_ELEN / 8)

// Width of an element count
`define OPREQ_VL_W 8

`endif

//--- opreq_pkg.sv
//////////////////////////////
// Read command types for the operand requesters.
// Element widths never exceed one data word.
//////////////////////////////

`include "opreq_macros.svh"

package opreq_pkg;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

  typedef logic [`OPREQ_VL_W-1:0] vl_t;

  // One operand read, base word plus element count
  typedef struct packed {
    vrf_pkg::word_addr_u addr;
    vl_t                 vl;
    eew_e                eew;
  } read_cmd_t;

  // Elements packed into one data word
  function automatic vl_t elems_per_word(eew_e eew);
    return vl_t'(`OPREQ_STRB_W) >> eew;
  endfunction

endpackage

//--- read_requester.sv
//////////////////////////////
// Turns one read command into word reads, one per grant.
// The request holds while queue_ready_i stays high. The next
// command can be taken in the cycle of the last grant.
//////////////////////////////

module read_requester (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  opreq_pkg::read_cmd_t  cmd_i,
  output logic                  cmd_ready_o,
  input  logic                  queue_ready_i,
  output logic                  issued_o,
  vrf_port_if.master            port
);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e              state_d, state_q;
  vrf_pkg::word_addr_u addr_d, addr_q;
  opreq_pkg::vl_t      len_d, len_q;
  opreq_pkg::eew_e     eew_d, eew_q;
  opreq_pkg::vl_t      epw;

  assign epw = opreq_pkg::elems_per_word(eew_q);

  // Read access toward the bank of the current word
  assign port.req   = (state_q == REQUESTING) && queue_ready_i;
  assign port.addr  = addr_q;
  assign port.wen   = 1'b0;
  assign port.wdata = '0;
  assign port.be    = '0;

  assign issued_o = port.req && port.gnt;

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    len_d       = len_q;
    eew_d       = eew_q;
    cmd_ready_o = 1'b0;

    case (state_q)
      IDLE: begin
        cmd_ready_o = 1'b1;
      end
      REQUESTING: begin
        if (issued_o) begin
          addr_d.idx = addr_q.idx + 1'b1;
          // Last word may hold fewer elements than fit
          len_d = (len_q <= epw) ? '0 : len_q - epw;
          if (len_d == '0) begin
            state_d     = IDLE;
            cmd_ready_o = 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Take a new command, back to back after the last word
    if (cmd_valid_i && cmd_ready_o) begin
      addr_d  = cmd_i.addr;
      len_d   = cmd_i.vl;
      eew_d   = cmd_i.eew;
      state_d = (cmd_i.vl != '0) ? REQUESTING : IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      len_q   <= '0;
      eew_q   <= opreq_pkg::EW64;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      len_q   <= len_d;
      eew_q   <= eew_d;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the operand requester testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f operand_requester.f \
  --top-module tb_operand_requester

out=$(./obj_dir/Vtb_operand_requester +verilator+error+limit+1000 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tb_operand_requester.sv
//////////////////////////////
// Testbench of the operand requester core.
// The bound assertions do the checking. The stimulus here
// reaches each behavior and waits for it to complete.
//////////////////////////////

`include "opreq_macros.svh"

module tb_operand_requester;

  localparam int unsigned NrTests       = 5;
  localparam int unsigned CyclesPerTest = 200;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                  [1:0]                 cmd_valid;
  vrf_pkg::word_addr_u   [1:0]                 cmd_addr;
  opreq_pkg::vl_t        [1:0]                 cmd_vl;
  opreq_pkg::eew_e       [1:0]                 cmd_eew;
  logic                  [1:0]                 cmd_ready;
  logic                  [1:0]                 queue_ready;
  logic                  [1:0]                 issued;
  logic                                        alu_req;
  vrf_pkg::word_addr_u                         alu_addr;
  vrf_pkg::elen_t                              alu_wdata;
  vrf_pkg::strb_t                              alu_be;
  logic                                        alu_gnt;
  logic                                        ldu_req;
  vrf_pkg::word_addr_u                         ldu_addr;
  vrf_pkg::elen_t                              ldu_wdata;
  vrf_pkg::strb_t                              ldu_be;
  logic                                        ldu_gnt;
  logic                  [`OPREQ_NR_BANKS-1:0] vrf_req;
  vrf_pkg::row_t         [`OPREQ_NR_BANKS-1:0] vrf_row;
  logic                  [`OPREQ_NR_BANKS-1:0] vrf_wen;
  vrf_pkg::elen_t        [`OPREQ_NR_BANKS-1:0] vrf_wdata;
  vrf_pkg::strb_t        [`OPREQ_NR_BANKS-1:0] vrf_be;
  vrf_pkg::master_e      [`OPREQ_NR_BANKS-1:0] vrf_src;

  logic [31:0] rng_state = 32'd37705;
  logic        ready_random = 1'b0;
  int          ldu_sent = 0;
  int          ldu_seen = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;
  int unsigned fails_seen = 0;

  bind operand_requester operand_requester_props u_props (.*);

  operand_requester u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid),
    .cmd_addr_i    (cmd_addr),
    .cmd_vl_i      (cmd_vl),
    .cmd_eew_i     (cmd_eew),
    .cmd_ready_o   (cmd_ready),
    .queue_ready_i (queue_ready),
    .issued_o      (issued),
    .alu_req_i     (alu_req),
    .alu_addr_i    (alu_addr),
    .alu_wdata_i   (alu_wdata),
    .alu_be_i      (alu_be),
    .alu_gnt_o     (alu_gnt),
    .ldu_req_i     (ldu_req),
    .ldu_addr_i    (ldu_addr),
    .ldu_wdata_i   (ldu_wdata),
    .ldu_be_i      (ldu_be),
    .ldu_gnt_o     (ldu_gnt),
    .vrf_req_o     (vrf_req),
    .vrf_row_o     (vrf_row),
    .vrf_wen_o     (vrf_wen),
    .vrf_wdata_o   (vrf_wdata),
    .vrf_be_o      (vrf_be),
    .vrf_src_o     (vrf_src)
  );

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Queue back-pressure of about one cycle in four when random
  initial begin
    logic [31:0] r;
    queue_ready = 2'b11;
    forever begin
      @(posedge clk_i);
      #1;
      r = xorshift();
      queue_ready = ready_random ? (r[1:0] | r[3:2]) : 2'b11;
    end
  end

  // Count completed load writes as the done signal of the load test
  always @(negedge clk_i) begin
    for (int b = 0; b < `OPREQ_NR_BANKS; b++) begin
      if (vrf_req[b] && vrf_src[b] == vrf_pkg::LDU) begin
        ldu_seen <= ldu_seen + 1;
      end
    end
  end

  initial begin
    repeat (NrTests * CyclesPerTest) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a test did not complete",
             NrTests * CyclesPerTest);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////
  // Drivers
  ////////////////////////////////

  // First command of each call has vl zero
  task automatic issue_reads(input int q, input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      cmd_addr[q].idx = r[4:0];
      cmd_vl[q]       = (i == 0) ? '0 : opreq_pkg::vl_t'(r[11:8]);
      cmd_eew[q]      = opreq_pkg::eew_e'(r[17:16]);
      cmd_valid[q]    = 1'b1;
      do @(negedge clk_i); while (!cmd_ready[q]);
      @(posedge clk_i);
      #1;
      cmd_valid[q] = 1'b0;
    end
    // Ready high again marks the last word
    do @(negedge clk_i); while (!cmd_ready[q]);
  endtask

  task automatic drive_alu(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      alu_addr.idx = r[4:0];
      alu_be       = r[31:24];
      alu_wdata    = {xorshift(), xorshift()};
      alu_req      = 1'b1;
      do @(negedge clk_i); while (!alu_gnt);
      @(posedge clk_i);
      #1;
    end
    alu_req = 1'b0;
  endtask

  task automatic stream_loads(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      ldu_addr.idx = r[4:0];
      ldu_be       = r[15:8];
      ldu_wdata    = {xorshift(), xorshift()};
      ldu_req      = 1'b1;
      do @(negedge clk_i); while (!ldu_gnt);
      ldu_sent++;
      @(posedge clk_i);
      #1;
    end
    ldu_req = 1'b0;
    while (ldu_seen != ldu_sent) @(negedge clk_i);
  endtask

  // The last access of a test is checked at the next rising edge
  task automatic report_test(input string name);
    int unsigned now_fails;
    @(posedge clk_i);
    #1;
    now_fails = u_dut.u_props.fail_cnt;
    test_cnt++;
    if (now_fails != fails_seen) begin
      failed_tests++;
      $display("test %0d %s: FAIL with %0d assertion failures", test_cnt, name,
               now_fails - fails_seen);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
    fails_seen = now_fails;
  endtask

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////

  initial begin
    int unsigned total_fails;
    rst_ni    = 1'b0;
    cmd_valid = '0;
    cmd_addr  = '0;
    cmd_vl    = '0;
    cmd_eew   = '{opreq_pkg::EW64, opreq_pkg::EW64};
    alu_req   = 1'b0;
    alu_addr  = '0;
    alu_wdata = '0;
    alu_be    = '0;
    ldu_req   = 1'b0;
    ldu_addr  = '0;
    ldu_wdata = '0;
    ldu_be    = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    repeat (4) @(posedge clk_i);
    #1;
    report_test("reset and idle");

    ready_random = 1'b1;
    fork
      issue_reads(0, 6);
      issue_reads(1, 6);
    join
    report_test("reads with back-pressure");

    ready_random = 1'b0;
    fork
      issue_reads(0, 3);
      drive_alu(12);
    join
    report_test("ALU writes");

    fork
      issue_reads(1, 3);
      stream_loads(10);
      drive_alu(6);
    join
    report_test("load writes");

    // ALU back to back against read A and read B
    fork
      issue_reads(0, 4);
      issue_reads(1, 2);
      drive_alu(16);
    join
    report_test("contention");

    total_fails = u_dut.u_props.fail_cnt;
    $display("tests run %0d, failing %0d, assertion failures %0d",
             test_cnt, failed_tests, total_fails);
    if (failed_tests == 0 && total_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vrf_pkg.sv
//////////////////////////////
// Types for the banked register file.
// A word address is one flat index. Its low bits select the bank
// and its high bits select the row in that bank.
//////////////////////////////

`include "opreq_macros.svh"

package vrf_pkg;

  localparam int unsigned BankW = $clog2(`OPREQ_NR_BANKS);
  localparam int unsigned RowW  = $clog2(`OPREQ_NR_ROWS);

  typedef logic [RowW-1:0]  row_t;
  typedef logic [BankW-1:0] bank_t;

  // Row and bank split of a word address
  typedef struct packed {
    row_t  row;
    bank_t bank;
  } word_rb_t;

  // The same word address seen as a flat index or as row and bank
  typedef union packed {
    logic [RowW+BankW-1:0] idx;
    word_rb_t              rb;
  } word_addr_u;

  typedef logic [`OPREQ_ELEN-1:0]   elen_t;
  typedef logic [`OPREQ_STRB_W-1:0] strb_t;

  // Source of a bank access
  typedef enum logic [1:0] {
    READ_A,
    READ_B,
    ALU,
    LDU
  } master_e;

endpackage

//--- vrf_port_if.sv
//////////////////////////////
// Path from one master to all VRF banks.
// Only the bank in addr selects may grant. Each bank arbiter
// drives its own bank_gnt bit and the top folds them into gnt.
//////////////////////////////

`include "opreq_macros.svh"

interface vrf_port_if;

  logic                req;
  vrf_pkg::word_addr_u addr;
  logic                wen;
  vrf_pkg::elen_t      wdata;
  vrf_pkg::strb_t      be;

  // One grant bit per bank, and their OR
  wire [`OPREQ_NR_BANKS-1:0] bank_gnt;
  logic                      gnt;

  modport master (output req, addr, wen, wdata, be, input gnt);

  modport arbiter (input req, addr, wen, wdata, be, output bank_gnt);

endinterface
